//--- src/monitor_config.svh
`ifndef MONITOR_CONFIG_SVH
`define MONITOR_CONFIG_SVH

// cores watched by the monitor
`define MON_NUM_CORE 8

// logical processes in the simulation
`define MON_NUM_LP 8

// event timestamp width
`define MON_TIME_W 16

// full message width on the queue/core bus
`define MON_MSG_W 32

// one visit per core, one idle slot, one report slot
`define MON_GVT_PERIOD (`MON_NUM_CORE + 2)

`endif

//--- src/msg_pkg.sv
`default_nettype none

`include "monitor_config.svh"

package msg_pkg;

   // field widths of the event message
   localparam int lp_w    = $clog2(`MON_NUM_LP);
   localparam int spare_w = `MON_MSG_W - `MON_TIME_W - lp_w;

   typedef logic [`MON_TIME_W-1:0] sim_time_t;
   typedef logic [lp_w-1:0]        lp_id_t;

   // timestamp in the low bits, lp above it, rest ignored
   typedef struct packed {
      logic [spare_w-1:0] spare;
      lp_id_t             lp;
      sim_time_t          ts;
   } msg_t;

endpackage

`default_nettype wire

//--- src/monitor_pkg.sv
`default_nettype none

`include "monitor_config.svh"

package monitor_pkg;
   import msg_pkg::*;

   localparam int core_w = $clog2(`MON_NUM_CORE);

   // register levels in the min search tree
   localparam int tree_depth = core_w;

   typedef logic [core_w-1:0]        core_id_t;
   typedef logic [`MON_NUM_CORE-1:0] core_mask_t;

   // per-core table contents, index is the core number
   typedef sim_time_t [`MON_NUM_CORE-1:0] core_time_arr_t;
   typedef lp_id_t    [`MON_NUM_CORE-1:0] core_lp_arr_t;

   // what a captured event asks the monitor to do
   typedef enum logic [1:0] {
      op_none     = 2'd0,
      op_dispatch = 2'd1,
      op_return   = 2'd2
   } op_t;

endpackage

`default_nettype wire

//--- src/monitor_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// registered event, one cycle wide
interface event_if;
   import monitor_pkg::*;
   import msg_pkg::*;

   op_t        op;
   core_id_t   core;
   lp_id_t     lp;
   // event timestamp
   sim_time_t  ts;
   // core_active as sampled with the strobe
   core_mask_t active;

   modport src        (output op, core, lp, ts, active);
   // table only needs the write fields
   modport table_side (input op, core, lp, ts);
   modport ctrl_side  (input op, core, lp, active);
endinterface

// candidate set into the min tree and the winner back out
interface search_if;
   import monitor_pkg::*;

   logic           req_vld;
   core_mask_t     cand_mask;
   core_time_arr_t cand_times;
   // low means no candidate matched
   logic           res_vld;
   core_id_t       res_id;

   modport requester (output req_vld, cand_mask, cand_times,
                      input  res_vld, res_id);
   modport tree      (input  req_vld, cand_mask, cand_times,
                      output res_vld, res_id);
endinterface

`default_nettype wire

//--- src/event_capture.sv
`timescale 1ns/1ps
`default_nettype none

module event_capture (
   input  logic                    clk,
   input  logic                    reset,
   input  msg_pkg::msg_t           msg,
   input  logic                    dispatch_vld,
   input  logic                    return_vld,
   input  monitor_pkg::core_id_t   core_id,
   input  monitor_pkg::core_mask_t core_active,
   event_if.src                    ev
);
   import monitor_pkg::*;

   op_t op_in;

   // strobes to op code, never both in one cycle
   always_comb begin
      op_in = op_none;
      if (dispatch_vld)
         op_in = op_dispatch;
      else if (return_vld)
         op_in = op_return;
   end

   // control side, cleared so nothing fires out of reset
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ev.op     <= op_none;
         ev.active <= '0;
      end else begin
         ev.op     <= op_in;
         ev.active <= core_active;
      end
   end

   // message fields, only meaningful while op is set
   always_ff @(posedge clk) begin
      ev.core <= core_id;
      ev.lp   <= msg.lp;
      ev.ts   <= msg.ts;
   end

endmodule

`default_nettype wire

//--- src/core_table.sv
`timescale 1ns/1ps
`default_nettype none

module core_table (
   input  logic                        clk,
   input  logic                        reset,
   event_if.table_side                 ev,
   output monitor_pkg::core_lp_arr_t   table_lp,
   output monitor_pkg::core_time_arr_t table_time
);
   import monitor_pkg::*;

   logic wr_en;

   // only a dispatch brings a new lp/time to a core
   assign wr_en = (ev.op == op_dispatch);

   // lp of the event each core is running
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         table_lp <= '0;
      end else if (wr_en) begin
         table_lp[ev.core] <= ev.lp;
      end
   end

   // timestamp of that event
   // a return leaves the entry alone, core_active tells it is stale
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         table_time <= '0;
      end else if (wr_en) begin
         table_time[ev.core] <= ev.ts;
      end
   end

   // readers see the old entry on the write edge
   // release_ctrl relies on that for the dispatched core only
   // and masks that core out anyway

endmodule

`default_nettype wire

//--- src/release_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module release_ctrl (
   input  logic                        clk,
   input  logic                        reset,
   event_if.ctrl_side                  ev,
   input  monitor_pkg::core_lp_arr_t   table_lp,
   input  monitor_pkg::core_time_arr_t table_time,
   search_if.requester                 srch,
   output monitor_pkg::core_mask_t     stall
);
   import monitor_pkg::*;
   import msg_pkg::*;

   lp_id_t     key_lp;
   core_mask_t match;
   op_t        req_op;
   core_id_t   req_core;
   op_t        pipe_op   [tree_depth];
   core_id_t   pipe_core [tree_depth];
   op_t        tail_op;
   core_id_t   tail_core;
   core_mask_t set_mask;
   core_mask_t clr_mask;

   // dispatch looks for the new lp, return for the lp the core just left
   assign key_lp = (ev.op == op_return) ? table_lp[ev.core] : ev.lp;

   // other active cores on the same lp
   always_comb begin
      for (int i = 0; i < $bits(core_mask_t); i++) begin
         match[i] = ev.active[i] && (core_id_t'(i) != ev.core) &&
                    (table_lp[i] == key_lp);
      end
   end

   // request stage, first of the ops in flight
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         req_op <= op_none;
      else
         req_op <= ev.op;
   end

   always_ff @(posedge clk) begin
      req_core        <= ev.core;
      srch.cand_mask  <= match;
      srch.cand_times <= table_time;
   end

   assign srch.req_vld = (req_op != op_none);

   // op and core ride alongside the tree levels
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int k = 0; k < tree_depth; k++)
            pipe_op[k] <= op_none;
      end else begin
         pipe_op[0] <= req_op;
         for (int k = 1; k < tree_depth; k++)
            pipe_op[k] <= pipe_op[k-1];
      end
   end

   always_ff @(posedge clk) begin
      pipe_core[0] <= req_core;
      for (int k = 1; k < tree_depth; k++)
         pipe_core[k] <= pipe_core[k-1];
   end

   // lined up with res_vld/res_id
   assign tail_op   = pipe_op[tree_depth-1];
   assign tail_core = pipe_core[tree_depth-1];

   always_comb begin
      set_mask = '0;
      clr_mask = '0;
      // new event always holds its core first
      if (ev.op == op_dispatch)
         set_mask[ev.core] = 1'b1;
      // returning core is free at once
      if (ev.op == op_return)
         clr_mask[ev.core] = 1'b1;
      // no other core on that lp, let the dispatched one run
      if (tail_op == op_dispatch && !srch.res_vld)
         clr_mask[tail_core] = 1'b1;
      // oldest waiter on the returned lp goes next
      if (tail_op == op_return && srch.res_vld)
         clr_mask[srch.res_id] = 1'b1;
   end

   // release beats set on the same edge
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         stall <= '0;
      else
         stall <= (stall | set_mask) & ~clr_mask;
   end

endmodule

`default_nettype wire

//--- src/min_tree.sv
`timescale 1ns/1ps
`default_nettype none

`include "monitor_config.svh"

module min_tree (
   input  logic   clk,
   search_if.tree srch
);
   import monitor_pkg::*;
   import msg_pkg::*;

   localparam int num_leaf = `MON_NUM_CORE;

   // heap layout, node k has children 2k and 2k+1
   // leaves sit at num_leaf..2*num_leaf-1, root at 1
   sim_time_t node_t  [1:2*num_leaf-1];
   core_id_t  node_id [1:2*num_leaf-1];
   logic      node_v  [1:2*num_leaf-1];

   // leaves, masked candidates straight from the request register
   for (genvar i = 0; i < num_leaf; i++) begin : leaf
      assign node_t[num_leaf+i]  = srch.cand_times[i];
      assign node_id[num_leaf+i] = core_id_t'(i);
      assign node_v[num_leaf+i]  = srch.req_vld && srch.cand_mask[i];
   end

   // every inner node is one register, so one stage per tree level
   for (genvar k = 1; k < num_leaf; k++) begin : cmp
      logic      take_right;
      sim_time_t r_t;
      core_id_t  r_id;
      logic      r_v;

      // right side only on strictly smaller, ties stay with lower core
      assign take_right = node_v[2*k+1] &&
                          (!node_v[2*k] || node_t[2*k+1] < node_t[2*k]);

      always_ff @(posedge clk) begin
         r_t  <= take_right ? node_t[2*k+1]  : node_t[2*k];
         r_id <= take_right ? node_id[2*k+1] : node_id[2*k];
         r_v  <= node_v[2*k] || node_v[2*k+1];
      end

      assign node_t[k]  = r_t;
      assign node_id[k] = r_id;
      assign node_v[k]  = r_v;
   end

   // root register
   assign srch.res_vld = node_v[1];
   assign srch.res_id  = node_id[1];

endmodule

`default_nettype wire

//--- src/gvt_sweep.sv
`timescale 1ns/1ps
`default_nettype none

`include "monitor_config.svh"

module gvt_sweep (
   input  logic                        clk,
   input  logic                        reset,
   input  monitor_pkg::core_mask_t     active,
   input  monitor_pkg::core_time_arr_t table_time,
   output msg_pkg::sim_time_t          min_time,
   output logic                        min_time_vld
);
   import monitor_pkg::*;
   import msg_pkg::*;

   localparam int period = `MON_GVT_PERIOD;
   localparam int cnt_w  = $clog2(period);

   logic [cnt_w-1:0] cnt;
   core_id_t         visit;
   logic             visit_hit;
   sim_time_t        run_min;

   // counts below the core count visit that core
   assign visit     = core_id_t'(cnt);
   assign visit_hit = (cnt < `MON_NUM_CORE) && active[visit] &&
                      (table_time[visit] < run_min);

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         cnt <= '0;
      else if (cnt == cnt_w'(period - 1))
         cnt <= '0;
      else
         cnt <= cnt + 1'b1;
   end

   // running min, all ones means no active core seen
   // output loads in the idle slot so it is steady under the pulse
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         run_min  <= '1;
         min_time <= '1;
      end else begin
         if (cnt == cnt_w'(period - 2))
            min_time <= run_min;
         if (cnt == cnt_w'(period - 1))
            run_min <= '1;
         else if (visit_hit)
            run_min <= table_time[visit];
      end
   end

   // one cycle every period
   assign min_time_vld = (cnt == cnt_w'(period - 1));

endmodule

`default_nettype wire

//--- src/core_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module core_monitor (
   input  logic                    clk,
   input  logic                    reset,
   input  msg_pkg::msg_t           msg,
   input  logic                    dispatch_vld,
   input  logic                    return_vld,
   input  monitor_pkg::core_id_t   core_id,
   input  monitor_pkg::core_mask_t core_active,
   output monitor_pkg::core_mask_t stall,
   output msg_pkg::sim_time_t      min_time,
   output logic                    min_time_vld
);
   import monitor_pkg::*;

   // shared table read ports
   core_lp_arr_t   table_lp;
   core_time_arr_t table_time;

   event_if  ev_bus ();
   search_if srch_bus ();

   // only place the raw strobes and message are sampled
   event_capture i_event_capture (
      .clk          (clk),
      .reset        (reset),
      .msg          (msg),
      .dispatch_vld (dispatch_vld),
      .return_vld   (return_vld),
      .core_id      (core_id),
      .core_active  (core_active),
      .ev           (ev_bus.src)
   );

   core_table i_core_table (
      .clk        (clk),
      .reset      (reset),
      .ev         (ev_bus.table_side),
      .table_lp   (table_lp),
      .table_time (table_time)
   );

   // candidates, in-flight ops and the stall register
   release_ctrl i_release_ctrl (
      .clk        (clk),
      .reset      (reset),
      .ev         (ev_bus.ctrl_side),
      .table_lp   (table_lp),
      .table_time (table_time),
      .srch       (srch_bus.requester),
      .stall      (stall)
   );

   min_tree i_min_tree (
      .clk  (clk),
      .srch (srch_bus.tree)
   );

   // sweep uses the live active mask, not the captured one
   gvt_sweep i_gvt_sweep (
      .clk          (clk),
      .reset        (reset),
      .active       (core_active),
      .table_time   (table_time),
      .min_time     (min_time),
      .min_time_vld (min_time_vld)
   );

endmodule

`default_nettype wire

//--- test/core_monitor_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "monitor_config.svh"

module core_monitor_chk (
   input logic                    clk,
   input logic                    reset,
   input logic                    return_vld,
   input monitor_pkg::core_id_t   core_id,
   input monitor_pkg::core_mask_t stall,
   input logic                    min_time_vld
);
   localparam int period = `MON_GVT_PERIOD;

   // reset clears stall by the following edge
   a_reset_stall: assert property (@(posedge clk) reset |=> stall == '0)
      else $error("stall not cleared under reset");

   // single cycle pulse
   a_vld_single: assert property (@(posedge clk) disable iff (reset)
      min_time_vld |=> !min_time_vld)
      else $error("min_time_vld high on two cycles in a row");

   // comes back once per sweep
   a_vld_period: assert property (@(posedge clk) disable iff (reset)
      min_time_vld |-> ##period min_time_vld)
      else $error("min_time_vld missing one sweep after the last pulse");

   // returning core runs free from the edge after capture
   a_return_free: assert property (@(posedge clk) disable iff (reset)
      return_vld |-> ##2 !stall[$past(core_id, 2)])
      else $error("returning core still stalled after its return");

endmodule

`default_nettype wire

//--- test/tb_core_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "monitor_config.svh"

module tb_core_monitor;
   import monitor_pkg::*;
   import msg_pkg::*;

   localparam int num_core = `MON_NUM_CORE;
   localparam int period   = `MON_GVT_PERIOD;
   // twice the reset plus the rough length of each test
   localparam int max_cycles = 2 * (5 + 12 + 10 + 30 + 64 + 24 + 24);

   logic        clk;
   logic        reset;
   msg_t        msg;
   logic        dispatch_vld;
   logic        return_vld;
   core_id_t    core_id;
   core_mask_t  core_active;
   core_mask_t  stall;
   sim_time_t   min_time;
   logic        min_time_vld;

   // reference state
   lp_id_t      m_lp   [num_core];
   sim_time_t   m_time [num_core];
   core_mask_t  exp_stall;
   core_mask_t  set_at [16];
   core_mask_t  clr_at [16];
   int          cyc;
   int          g_cnt;
   logic        gvt_chk;
   logic [31:0] lfsr;
   int          errors;
   int          checks;

   core_monitor i_core_monitor (
      .clk          (clk),
      .reset        (reset),
      .msg          (msg),
      .dispatch_vld (dispatch_vld),
      .return_vld   (return_vld),
      .core_id      (core_id),
      .core_active  (core_active),
      .stall        (stall),
      .min_time     (min_time),
      .min_time_vld (min_time_vld)
   );

   bind core_monitor core_monitor_chk i_core_monitor_chk (
      .clk          (clk),
      .reset        (reset),
      .return_vld   (return_vld),
      .core_id      (core_id),
      .stall        (stall),
      .min_time_vld (min_time_vld)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // galois lfsr for x^32+x^22+x^2+x+1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[14:0], lfsr[0]};
      end
   endtask

   // smallest time among other active cores on lp
   // lower core wins a tie
   function automatic int ref_winner(input core_mask_t act, input int self, input lp_id_t lp);
      int w;
      w = -1;
      for (int i = 0; i < num_core; i++)
         if (act[i] && i != self && m_lp[i] == lp && (w < 0 || m_time[i] < m_time[w]))
            w = i;
      return w;
   endfunction

   // sweep result is all ones with no active core
   function automatic sim_time_t ref_min(input core_mask_t act);
      sim_time_t m;
      m = '1;
      for (int i = 0; i < num_core; i++)
         if (act[i] && m_time[i] < m)
            m = m_time[i];
      return m;
   endfunction

   // expected stall, table and sweep count per edge
   always @(posedge clk) begin
      int w;
      int s;
      if (reset) begin
         exp_stall = '0;
         cyc       = 0;
         g_cnt     = 0;
         for (int i = 0; i < num_core; i++) begin
            m_lp[i]   = '0;
            m_time[i] = '0;
         end
         for (int k = 0; k < 16; k++) begin
            set_at[k] = '0;
            clr_at[k] = '0;
         end
      end else begin
         cyc   = cyc + 1;
         g_cnt = (g_cnt == period - 1) ? 0 : g_cnt + 1;
         s     = cyc % 16;
         // release wins over set on one edge
         exp_stall = (exp_stall | set_at[s]) & ~clr_at[s];
         set_at[s] = '0;
         clr_at[s] = '0;
         if (dispatch_vld) begin
            w = ref_winner(core_active, core_id, msg.lp);
            set_at[(cyc + 1) % 16][core_id] = 1'b1;
            if (w < 0)
               clr_at[(cyc + 5) % 16][core_id] = 1'b1;
            m_lp[core_id]   = msg.lp;
            m_time[core_id] = msg.ts;
         end else if (return_vld) begin
            w = ref_winner(core_active, core_id, m_lp[core_id]);
            clr_at[(cyc + 1) % 16][core_id] = 1'b1;
            if (w >= 0)
               clr_at[(cyc + 5) % 16][w] = 1'b1;
         end
      end
   end

   // outputs have settled by mid cycle
   always @(negedge clk) begin
      if (!reset) begin
         checks = checks + 1;
         if (stall !== exp_stall) begin
            errors = errors + 1;
            $display("Fail %0t: stall %b, expected %b", $time, stall, exp_stall);
         end
         if (min_time_vld !== (g_cnt == period - 1)) begin
            errors = errors + 1;
            $display("Fail %0t: min_time_vld %b out of step", $time, min_time_vld);
         end
         if (gvt_chk && min_time_vld && min_time !== ref_min(core_active)) begin
            errors = errors + 1;
            $display("Fail %0t: min_time %h, expected %h", $time, min_time,
                     ref_min(core_active));
         end
      end
   end

   initial begin
      int n;
      n = 0;
      while (n < max_cycles) begin
         @(posedge clk);
         n = n + 1;
      end
      $display("timeout: tests did not finish within %0d cycles", max_cycles);
      $display("TB FAILED");
      $finish;
   end

   // inputs change 2 ns after the rising edge
   task automatic step(input int n);
      repeat (n) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic send(input logic disp, input int core, input lp_id_t lp, input sim_time_t ts);
      msg.lp       = lp;
      msg.ts       = ts;
      dispatch_vld = disp;
      return_vld   = !disp;
      core_id      = core_id_t'(core);
      if (disp)
         core_active[core] = 1'b1;
      step(1);
      dispatch_vld = 1'b0;
      return_vld   = 1'b0;
      if (!disp)
         core_active[core] = 1'b0;
   endtask

   // stall is set one edge after capture so look from there on
   task automatic wait_free(input int core);
      step(1);
      while (stall[core] !== 1'b0)
         step(1);
   endtask

   task automatic wait_pulse();
      step(1);
      while (min_time_vld !== 1'b1)
         step(1);
   endtask

   task automatic report(input string name, input int e0);
      if (errors == e0)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, errors - e0);
   endtask

   task automatic test_reset();
      int e0;
      int n;
      e0 = errors;
      n  = 1;
      if (stall !== '0) begin
         errors = errors + 1;
         $display("Fail %0t: stall %b after reset", $time, stall);
      end
      while (min_time_vld !== 1'b1) begin
         step(1);
         n = n + 1;
      end
      if (n != period || min_time !== '1) begin
         errors = errors + 1;
         $display("Fail %0t: first pulse in cycle %0d with %h", $time, n, min_time);
      end
      step(1);
      gvt_chk = 1'b0;
      report("reset state", e0);
   endtask

   task automatic test_conflict();
      int e0;
      sim_time_t t;
      e0 = errors;
      rand_bits(16, t);
      send(1'b1, 1, 3'd1, t);
      wait_free(1);
      report("dispatch without conflict", e0);
      e0 = errors;
      // core 1 still runs lp 1
      rand_bits(16, t);
      send(1'b1, 2, 3'd1, t);
      step(8);
      if (stall[2] !== 1'b1) begin
         errors = errors + 1;
         $display("Fail %0t: core 2 let go while core 1 holds lp 1", $time);
      end
      send(1'b0, 1, 3'd1, '0);
      wait_free(2);
      send(1'b0, 2, 3'd1, '0);
      step(2);
      report("dispatch with conflict", e0);
   endtask

   task automatic test_waiters();
      int e0;
      int holder;
      int next;
      sim_time_t t;
      e0     = errors;
      holder = 3;
      send(1'b1, holder, 3'd5, 16'd100);
      step(7);
      for (int c = 4; c < 7; c++) begin
         // narrow range so equal times show up
         rand_bits(3, t);
         send(1'b1, c, 3'd5, t);
         step(7);
      end
      repeat (4) begin
         next = ref_winner(core_active, holder, 3'd5);
         send(1'b0, holder, 3'd5, '0);
         step(7);
         holder = next;
      end
      report("return with several waiters", e0);
   endtask

   task automatic test_back_to_back();
      int e0;
      sim_time_t t;
      e0 = errors;
      for (int c = 0; c < 4; c++) begin
         rand_bits(16, t);
         send(1'b1, c, lp_id_t'(c), t);
      end
      wait_free(3);
      report("back-to-back dispatches", e0);
   endtask

   task automatic test_gvt();
      int e0;
      e0 = errors;
      // one full sweep over a settled table first
      wait_pulse();
      step(1);
      gvt_chk = 1'b1;
      wait_pulse();
      step(1);
      gvt_chk = 1'b0;
      report("global minimum", e0);
   endtask

   initial begin
      reset        = 1'b1;
      msg          = '0;
      dispatch_vld = 1'b0;
      return_vld   = 1'b0;
      core_id      = '0;
      core_active  = '0;
      lfsr         = 32'h7649763b;
      errors       = 0;
      checks       = 0;
      gvt_chk      = 1'b1;
      step(5);
      reset = 1'b0;
      test_reset();
      test_conflict();
      test_waiters();
      test_back_to_back();
      test_gvt();
      $display("tests 6, checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+src
src/msg_pkg.sv
src/monitor_pkg.sv
src/monitor_ifs.sv
src/event_capture.sv
src/core_table.sv
src/release_ctrl.sv
src/min_tree.sv
src/gvt_sweep.sv
src/core_monitor.sv
test/core_monitor_chk.sv
test/tb_core_monitor.sv

//--- Bender.yml
package:
  name: core_monitor

sources:
  - include_dirs:
      - src
    files:
      - src/msg_pkg.sv
      - src/monitor_pkg.sv
      - src/monitor_ifs.sv
      - src/event_capture.sv
      - src/core_table.sv
      - src/release_ctrl.sv
      - src/min_tree.sv
      - src/gvt_sweep.sv
      - src/core_monitor.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/core_monitor_chk.sv
      - test/tb_core_monitor.sv
